/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_core
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)

/* rv_core.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_core #(
  parameter logic [31:0] reset_pc = 32'h0000_0000
) (
  input  logic        clock,
  input  logic        reset,
  output logic        wb_cyc,
  output logic        wb_stb,
  output logic        wb_we,
  output logic [31:0] wb_adr,
  input  logic [31:0] wb_dat_i,
  input  logic        wb_ack,
  output logic        retire_valid,
  output logic [4:0]  retire_rd,
  output logic [31:0] retire_data,
  output logic        illegal
);

  import rv_pkg::*;

  logic        inst_valid;
  logic [31:0] inst;
  logic [31:0] inst_pc;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [31:0] rdata1;
  logic [31:0] rdata2;
  logic        decode_valid;
  logic [31:0] dec_pc;
  alu_op_t     alu_op;
  logic [31:0] imm;
  logic        b_is_imm;
  logic        op_a_pc;
  src_t        src_a;
  src_t        src_b;
  logic [4:0]  rd;
  logic        r_wen;

  rv_fetch #(.reset_pc(reset_pc)) fetch0 (
    .clock(clock), .reset(reset),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_i(wb_dat_i), .wb_ack(wb_ack),
    .inst_valid(inst_valid), .inst(inst), .inst_pc(inst_pc)
  );

  rv_decode decode0 (
    .clock(clock), .reset(reset),
    .inst_valid(inst_valid), .inst(inst), .inst_pc(inst_pc),
    .rs1(rs1), .rs2(rs2),
    .decode_valid(decode_valid), .dec_pc(dec_pc), .alu_op(alu_op), .imm(imm),
    .b_is_imm(b_is_imm), .op_a_pc(op_a_pc), .src_a(src_a), .src_b(src_b),
    .rd(rd), .r_wen(r_wen), .illegal(illegal)
  );

  // written from the write-back register, which is also the retire port
  rv_regfile regfile0 (
    .clock(clock), .reset(reset),
    .rs1(rs1), .rs2(rs2), .rdata1(rdata1), .rdata2(rdata2),
    .wen(retire_valid), .waddr(retire_rd), .wdata(retire_data)
  );

  rv_execute execute0 (
    .clock(clock), .reset(reset),
    .decode_valid(decode_valid), .dec_pc(dec_pc), .alu_op(alu_op), .imm(imm),
    .b_is_imm(b_is_imm), .op_a_pc(op_a_pc), .src_a(src_a), .src_b(src_b),
    .rd(rd), .r_wen(r_wen), .rdata1(rdata1), .rdata2(rdata2),
    .wb_valid(retire_valid), .wb_rd(retire_rd), .wb_data(retire_data)
  );

endmodule

`default_nettype wire

/* rv_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_decode (
  input  logic            clock,
  input  logic            reset,
  input  logic            inst_valid,
  input  logic [31:0]     inst,
  input  logic [31:0]     inst_pc,
  output logic [4:0]      rs1,
  output logic [4:0]      rs2,
  output logic            decode_valid,
  output logic [31:0]     dec_pc,
  output rv_pkg::alu_op_t alu_op,
  output logic [31:0]     imm,
  output logic            b_is_imm,
  output logic            op_a_pc,
  output rv_pkg::src_t    src_a,
  output rv_pkg::src_t    src_b,
  output logic [4:0]      rd,
  output logic            r_wen,
  output logic            illegal
);

  import rv_pkg::*;

  logic [31:0] inst_q;
  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic        is_lui;
  logic        is_auipc;
  logic        is_op_imm;
  logic        is_op;
  logic        shift_ok;
  logic        op_ok;
  logic        legal;
  logic [4:0]  new_rs1;
  logic [4:0]  new_rs2;
  logic [4:0]  new_rd;
  logic [31:0] next_imm;
  alu_op_t     next_op;

  // destination of the instruction now in execute, headed for write-back
  logic [4:0]  x_rd;
  logic        x_wen;

  // the newer producer wins, x0 never forwards
  function automatic src_t pick_src(input logic [4:0] rs);
    pick_src = src_reg;
    if (rs != 5'd0 && r_wen && rs == rd) begin
      pick_src = src_ex;
    end else if (rs != 5'd0 && x_wen && rs == x_rd) begin
      pick_src = src_wb;
    end
  endfunction

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  assign is_lui    = (opcode == op_lui);
  assign is_auipc  = (opcode == op_auipc);
  assign is_op_imm = (opcode == op_imm);
  assign is_op     = (opcode == op_reg);

  // shifts take funct7 0, or 0100000 for the arithmetic right shift
  assign shift_ok = (funct7 == 7'b0000000) ||
                    (funct3 == 3'b101 && funct7 == 7'b0100000);
  // sub and sra are the only op encodings with funct7 0100000
  assign op_ok    = (funct7 == 7'b0000000) ||
                    (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));

  assign legal = is_lui || is_auipc || is_op && op_ok ||
                 is_op_imm && (funct3[1:0] != 2'b01 || shift_ok);

  assign new_rs1 = is_lui ? 5'd0 : inst[19:15];
  assign new_rs2 = inst[24:20];
  assign new_rd  = inst[11:7];

  // u-type for lui/auipc, i-type otherwise (shamt sits in the low bits)
  assign next_imm = (is_lui || is_auipc) ? {inst[31:12], 12'b0} :
                                           {{20{inst[31]}}, inst[31:20]};

  always_comb begin
    next_op = alu_add;
    if (is_lui) begin
      next_op = alu_pass_b;
    end else if (is_op_imm || is_op) begin
      case (funct3)
        3'b000:  next_op = (is_op && funct7[5]) ? alu_sub : alu_add;
        3'b001:  next_op = alu_sll;
        3'b010:  next_op = alu_slt;
        3'b011:  next_op = alu_sltu;
        3'b100:  next_op = alu_xor;
        3'b101:  next_op = funct7[5] ? alu_sra : alu_srl;
        3'b110:  next_op = alu_or;
        default: next_op = alu_and;
      endcase
    end
  end

  // register file reads come from the held word
  assign rs1 = (inst_q[6:0] == op_lui) ? 5'd0 : inst_q[19:15];
  assign rs2 = inst_q[24:20];

  always_ff @(posedge clock) begin
    if (reset) begin
      decode_valid <= 1'b0;
      r_wen        <= 1'b0;
      illegal      <= 1'b0;
      x_wen        <= 1'b0;
    end else begin
      // an illegal word goes on as a bubble
      decode_valid <= inst_valid && legal;
      r_wen        <= inst_valid && legal && (new_rd != 5'd0);
      illegal      <= inst_valid && !legal;
      x_wen        <= r_wen;
    end
  end

  always_ff @(posedge clock) begin
    inst_q   <= inst;
    dec_pc   <= inst_pc;
    alu_op   <= next_op;
    imm      <= next_imm;
    b_is_imm <= !is_op;
    op_a_pc  <= is_auipc;
    src_a    <= pick_src(new_rs1);
    src_b    <= pick_src(new_rs2);
    rd       <= new_rd;
    x_rd     <= rd;
  end

  a_illegal_no_write: assert property (
    @(posedge clock) disable iff (reset)
    illegal |-> !r_wen && !decode_valid
  );

endmodule

`default_nettype wire

/* rv_execute.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_execute (
  input  logic            clock,
  input  logic            reset,
  input  logic            decode_valid,
  input  logic [31:0]     dec_pc,
  input  rv_pkg::alu_op_t alu_op,
  input  logic [31:0]     imm,
  input  logic            b_is_imm,
  input  logic            op_a_pc,
  input  rv_pkg::src_t    src_a,
  input  rv_pkg::src_t    src_b,
  input  logic [4:0]      rd,
  input  logic            r_wen,
  input  logic [31:0]     rdata1,
  input  logic [31:0]     rdata2,
  output logic            wb_valid,
  output logic [4:0]      wb_rd,
  output logic [31:0]     wb_data
);

  import rv_pkg::*;

  logic        ex_valid;
  logic [4:0]  ex_rd;
  logic [31:0] ex_data;
  logic [31:0] fwd_a;
  logic [31:0] fwd_b;
  logic [31:0] op_a;
  logic [31:0] op_b;
  logic [31:0] result;

  function automatic logic [31:0] forward(input src_t sel, input logic [31:0] rf,
                                          input logic [31:0] xv, input logic [31:0] wv);
    case (sel)
      src_ex:  forward = xv;
      src_wb:  forward = wv;
      default: forward = rf;
    endcase
  endfunction

  assign fwd_a = forward(src_a, rdata1, ex_data, wb_data);
  assign fwd_b = forward(src_b, rdata2, ex_data, wb_data);

  // auipc adds to the pc, immediates replace rs2
  assign op_a = op_a_pc ? dec_pc : fwd_a;
  assign op_b = b_is_imm ? imm : fwd_b;

  always_comb begin
    case (alu_op)
      alu_add:  result = op_a + op_b;
      alu_sub:  result = op_a - op_b;
      alu_sll:  result = op_a << op_b[4:0];
      alu_slt:  result = {31'd0, $signed(op_a) < $signed(op_b)};
      alu_sltu: result = {31'd0, op_a < op_b};
      alu_xor:  result = op_a ^ op_b;
      alu_srl:  result = op_a >> op_b[4:0];
      alu_sra:  result = $signed(op_a) >>> op_b[4:0];
      alu_or:   result = op_a | op_b;
      alu_and:  result = op_a & op_b;
      default:  result = op_b;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      ex_valid <= 1'b0;
      wb_valid <= 1'b0;
    end else begin
      // only real register writes go on
      ex_valid <= decode_valid && r_wen;
      wb_valid <= ex_valid;
    end
  end

  always_ff @(posedge clock) begin
    ex_rd   <= rd;
    ex_data <= result;
    wb_rd   <= ex_rd;
    wb_data <= ex_data;
  end

  // decode never lets a write to x0 through
  a_no_x0_retire: assert property (
    @(posedge clock) disable iff (reset)
    wb_valid |-> wb_rd != 5'd0
  );

endmodule

`default_nettype wire

/* rv_fetch.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_fetch #(
  parameter logic [31:0] reset_pc = 32'h0000_0000
) (
  input  logic        clock,
  input  logic        reset,
  output logic        wb_cyc,
  output logic        wb_stb,
  output logic        wb_we,
  output logic [31:0] wb_adr,
  input  logic [31:0] wb_dat_i,
  input  logic        wb_ack,
  output logic        inst_valid,
  output logic [31:0] inst,
  output logic [31:0] inst_pc
);

  typedef enum logic {
    st_gap,
    st_req
  } state_t;

  state_t      state;
  logic [31:0] pc;
  logic        done;

  // one classic read per word, cyc and stb move together
  assign wb_cyc = (state == st_req);
  assign wb_stb = wb_cyc;
  assign wb_we  = 1'b0;
  assign wb_adr = pc;

  assign done = (state == st_req) && wb_ack;

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= st_gap;
      pc         <= reset_pc;
      inst_valid <= 1'b0;
    end else begin
      inst_valid <= done;
      case (state)
        st_gap: begin
          state <= st_req;
        end
        default: begin
          // hold the request until the slave acks
          if (wb_ack) begin
            state <= st_gap;
            pc    <= pc + 32'd4;
          end
        end
      endcase
    end
  end

  // word and its address go to decode on the cycle after ack
  always_ff @(posedge clock) begin
    if (done) begin
      inst    <= wb_dat_i;
      inst_pc <= pc;
    end
  end

  // address must hold through wait states
  a_adr_stable: assert property (
    @(posedge clock) disable iff (reset)
    wb_stb && !wb_ack |=> $stable(wb_adr)
  );

endmodule

`default_nettype wire

/* rv_pkg.sv */
`default_nettype none

package rv_pkg;

  // major opcodes of the kept rv32i groups
  localparam logic [6:0] op_lui   = 7'b0110111;
  localparam logic [6:0] op_auipc = 7'b0010111;
  localparam logic [6:0] op_imm   = 7'b0010011;
  localparam logic [6:0] op_reg   = 7'b0110011;

  // alu operation, alu_pass_b hands operand b straight through (lui)
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_t;

  // where one alu operand comes from
  typedef enum logic [1:0] {
    src_reg,
    src_ex,
    src_wb
  } src_t;

endpackage

`default_nettype wire

/* rv_regfile.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_regfile (
  input  logic        clock,
  input  logic        reset,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  output logic [31:0] rdata1,
  output logic [31:0] rdata2,
  input  logic        wen,
  input  logic [4:0]  waddr,
  input  logic [31:0] wdata
);

  logic [31:0] regs [1:31];
  logic        do_write;

  // x0 is not stored, no writes while in reset
  assign do_write = wen && (waddr != 5'd0) && !reset;

  always_ff @(posedge clock) begin
    if (do_write) begin
      regs[waddr] <= wdata;
    end
  end

  // same-cycle write shows through to the readers
  always_comb begin
    if (rs1 == 5'd0) begin
      rdata1 = 32'd0;
    end else if (do_write && waddr == rs1) begin
      rdata1 = wdata;
    end else begin
      rdata1 = regs[rs1];
    end
  end

  always_comb begin
    if (rs2 == 5'd0) begin
      rdata2 = 32'd0;
    end else if (do_write && waddr == rs2) begin
      rdata2 = wdata;
    end else begin
      rdata2 = regs[rs2];
    end
  end

endmodule

`default_nettype wire

/* src.f */
rv_pkg.sv
rv_fetch.sv
rv_decode.sv
rv_regfile.sv
rv_execute.sv
rv_core.sv
tb_core.sv

/* tb_core.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_core;

  import rv_pkg::*;

  localparam logic [31:0] start_pc = 32'h100;
  localparam logic [31:0] nop_word = {12'd0, 5'd0, 3'd0, 5'd0, op_imm};

  // funct3 values of the integer groups
  localparam int f_add  = 0;
  localparam int f_sll  = 1;
  localparam int f_slt  = 2;
  localparam int f_sltu = 3;
  localparam int f_xor  = 4;
  localparam int f_sr   = 5;
  localparam int f_or   = 6;
  localparam int f_and  = 7;

  logic        clock = 1'b0;
  logic        reset = 1'b1;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [31:0] wb_adr;
  logic [31:0] wb_dat_i = 32'd0;
  logic        wb_ack = 1'b0;
  logic        retire_valid;
  logic [4:0]  retire_rd;
  logic [31:0] retire_data;
  logic        illegal;

  // program words by byte address, anything not loaded reads as a nop
  logic [31:0] mem [logic [31:0]];
  logic [31:0] load_pc;

  // reference registers and the retirements they predict, in program order
  logic [31:0] regs_m [0:31];
  logic [4:0]  exp_rd [$];
  logic [31:0] exp_val [$];
  int          mon_head = 0;

  string       test_name;
  int          run_errors = 0;
  int          mon_errors = 0;
  int          bus_errors = 0;
  int          illegal_exp;
  int          illegal_seen = 0;
  int          budget_words = 0;
  int          cycle_count = 0;
  logic        random_waits = 1'b0;
  logic [31:0] lfsr = 32'hb952;

  // bus slave state
  logic        busy = 1'b0;
  int          wait_left = 0;
  logic [31:0] req_adr;
  logic [31:0] next_adr = start_pc;

  rv_core #(.reset_pc(start_pc)) dut0 (
    .clock(clock), .reset(reset),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_i(wb_dat_i), .wb_ack(wb_ack),
    .retire_valid(retire_valid), .retire_rd(retire_rd), .retire_data(retire_data),
    .illegal(illegal)
  );

  always #4 clock = ~clock;

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // two fresh bits, 0 to 3 wait states
  task automatic take_wait(output int n);
    n = 0;
    for (int i = 0; i < 2; i++) begin
      lfsr = lfsr_next(lfsr);
      n = {n[30:0], lfsr[0]};
    end
  endtask

  function automatic logic [31:0] fetch_word(input logic [31:0] adr);
    if (mem.exists(adr)) begin
      fetch_word = mem[adr];
    end else begin
      fetch_word = nop_word;
    end
  endfunction

  // integer result by funct3, alt selects sub and sra
  function automatic logic [31:0] rv32i_result(input int f3, input logic alt,
                                               input logic [31:0] a, input logic [31:0] b);
    case (f3)
      f_add:  rv32i_result = alt ? a - b : a + b;
      f_sll:  rv32i_result = a << b[4:0];
      f_slt:  rv32i_result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      f_sltu: rv32i_result = (a < b) ? 32'd1 : 32'd0;
      f_xor:  rv32i_result = a ^ b;
      f_sr: begin
        if (alt) begin
          rv32i_result = $signed(a) >>> b[4:0];
        end else begin
          rv32i_result = a >> b[4:0];
        end
      end
      f_or:   rv32i_result = a | b;
      default: rv32i_result = a & b;
    endcase
  endfunction

  task automatic store_word(input logic [31:0] word);
    mem[load_pc] = word;
    load_pc = load_pc + 32'd4;
    budget_words++;
  endtask

  // x0 is never written and never retires
  task automatic expect_write(input int rd, input logic [31:0] value);
    if (rd != 0) begin
      regs_m[rd] = value;
      exp_rd.push_back(rd[4:0]);
      exp_val.push_back(value);
    end
  endtask

  // srai passes 12'h400 | shamt as its immediate
  task automatic imm_op(input int f3, input int rd, input int rs1, input int imm);
    logic [11:0] imm12;
    logic [31:0] b;
    imm12 = imm[11:0];
    b = {{20{imm12[11]}}, imm12};
    expect_write(rd, rv32i_result(f3, f3 == f_sr && imm12[10], regs_m[rs1], b));
    store_word({imm12, rs1[4:0], f3[2:0], rd[4:0], op_imm});
  endtask

  task automatic reg_op(input int f7, input int f3, input int rd, input int rs1, input int rs2);
    expect_write(rd, rv32i_result(f3, f7[5], regs_m[rs1], regs_m[rs2]));
    store_word({f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op_reg});
  endtask

  // auipc adds the address of its own word
  task automatic upper_op(input logic [6:0] opcode, input int rd, input int upper);
    expect_write(rd, {upper[19:0], 12'd0} + (opcode == op_auipc ? load_pc : 32'd0));
    store_word({upper[19:0], rd[4:0], opcode});
  endtask

  task automatic start_test(input string name);
    test_name = name;
    mem.delete();
    load_pc = start_pc;
    illegal_exp = 0;
    random_waits <= 1'b0;
  endtask

  // reset, wait for every predicted retirement, then watch for extras
  task automatic run_program;
    int illegal_base;
    illegal_base = illegal_seen;
    @(negedge clock);
    reset <= 1'b1;
    repeat (4) @(negedge clock);
    reset <= 1'b0;
    while (mon_head != exp_rd.size()) begin
      @(negedge clock);
    end
    repeat (16) @(negedge clock);
    if (illegal_seen - illegal_base != illegal_exp) begin
      $display("%s: illegal pulsed %0d times, %0d expected", test_name,
               illegal_seen - illegal_base, illegal_exp);
      run_errors++;
    end
  endtask

  task automatic finish_run(input int timeouts);
    int total;
    total = run_errors + mon_errors + bus_errors + timeouts;
    $display("error counts: retire %0d, bus %0d, illegal %0d, timeout %0d",
             mon_errors, bus_errors, run_errors, timeouts);
    if (total == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  endtask

  // wishbone slave, answers one read at a time
  always @(negedge clock) begin
    if (reset) begin
      wb_ack <= 1'b0;
      busy = 1'b0;
      next_adr = start_pc;
    end else if (wb_ack) begin
      // ack was taken at the last rising edge
      wb_ack <= 1'b0;
      busy = 1'b0;
      if (wb_cyc !== 1'b0) begin
        $display("%s: cyc still high in the cycle after ack", test_name);
        bus_errors++;
      end
    end else if (wb_cyc === 1'b1) begin
      if (wb_stb !== 1'b1 || wb_we !== 1'b0) begin
        $display("%s: stb low or we high during an instruction read", test_name);
        bus_errors++;
      end
      if (!busy) begin
        busy = 1'b1;
        req_adr = wb_adr;
        wait_left = 0;
        if (random_waits) begin
          take_wait(wait_left);
        end
        if (wb_adr !== next_adr) begin
          $display("[ERROR] %s: expected address %h, actual address %h",
                   test_name, next_adr, wb_adr);
          bus_errors++;
        end
        next_adr = next_adr + 32'd4;
      end else if (wb_adr !== req_adr) begin
        $display("%s: address changed during wait states", test_name);
        bus_errors++;
      end
      if (wait_left == 0) begin
        wb_ack <= 1'b1;
        wb_dat_i <= fetch_word(wb_adr);
      end else begin
        wait_left--;
      end
    end else if (busy) begin
      $display("%s: cyc dropped before ack", test_name);
      bus_errors++;
    end
  end

  // retire monitor
  always @(negedge clock) begin
    if (!reset && illegal === 1'b1) begin
      illegal_seen++;
    end
    if (!reset && retire_valid === 1'b1) begin
      if (mon_head >= exp_rd.size()) begin
        $display("%s: unexpected retirement of x%0d = %h", test_name, retire_rd, retire_data);
        mon_errors++;
      end else begin
        if (retire_rd !== exp_rd[mon_head] || retire_data !== exp_val[mon_head]) begin
          $display("[ERROR] %s: expected x%0d = %h, actual x%0d = %h", test_name,
                   exp_rd[mon_head], exp_val[mon_head], retire_rd, retire_data);
          mon_errors++;
        end
        mon_head++;
      end
    end
  end

  // each loaded word buys 40 cycles
  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count > budget_words * 40) begin
      $display("timeout in %s after %0d cycles, %0d retirements never arrived",
               test_name, cycle_count, exp_rd.size() - mon_head);
      finish_run(1);
    end
  end

  task automatic test_imm_group;
    start_test("imm_group");
    imm_op(f_add, 1, 0, 100);
    imm_op(f_add, 2, 0, -7);
    imm_op(f_slt, 3, 2, -5);
    imm_op(f_slt, 4, 1, -5);
    imm_op(f_sltu, 5, 2, 5);
    imm_op(f_sltu, 6, 1, -1);
    imm_op(f_xor, 7, 1, -1);
    imm_op(f_or, 8, 2, 'h0f0);
    imm_op(f_and, 9, 2, -16);
    imm_op(f_sll, 10, 2, 4);
    imm_op(f_sr, 11, 2, 3);
    imm_op(f_sr, 12, 2, 'h403);
    imm_op(f_add, 13, 1, -2048);
    run_program();
  endtask

  task automatic test_reg_group;
    start_test("reg_group");
    imm_op(f_add, 1, 0, -300);
    imm_op(f_add, 2, 0, 37);
    reg_op(0, f_add, 3, 1, 2);
    reg_op('h20, f_add, 4, 1, 2);
    reg_op(0, f_sll, 5, 1, 2);
    reg_op(0, f_slt, 6, 1, 2);
    reg_op(0, f_sltu, 7, 1, 2);
    reg_op(0, f_xor, 8, 1, 2);
    reg_op(0, f_sr, 9, 1, 2);
    reg_op('h20, f_sr, 10, 1, 2);
    reg_op(0, f_or, 11, 1, 2);
    reg_op(0, f_and, 12, 1, 2);
    reg_op(0, f_sltu, 13, 2, 1);
    run_program();
  endtask

  // reads one, two and three instructions after the write
  task automatic test_dependences;
    start_test("dependences");
    imm_op(f_add, 1, 0, 5);
    imm_op(f_add, 2, 1, 1);
    imm_op(f_add, 3, 0, 9);
    reg_op(0, f_add, 4, 2, 1);
    imm_op(f_add, 5, 4, -2);
    imm_op(f_xor, 6, 0, 1);
    imm_op(f_add, 7, 0, 2);
    reg_op('h20, f_add, 8, 5, 4);
    reg_op(0, f_sll, 9, 8, 6);
    imm_op(f_add, 9, 9, 1);
    reg_op(0, f_or, 10, 9, 9);
    run_program();
  endtask

  task automatic test_upper;
    start_test("upper");
    upper_op(op_lui, 1, 'h12345);
    upper_op(op_auipc, 2, 'h1);
    imm_op(f_add, 0, 1, 5);
    reg_op(0, f_add, 3, 0, 1);
    upper_op(op_lui, 0, 'hfffff);
    upper_op(op_auipc, 4, 'hfffff);
    reg_op(0, f_or, 5, 0, 0);
    run_program();
  endtask

  // slli with funct7 0100000 sits in the middle as the illegal word
  task automatic test_random_waits;
    start_test("random_waits");
    random_waits <= 1'b1;
    imm_op(f_add, 1, 0, 77);
    imm_op(f_add, 2, 1, -100);
    upper_op(op_lui, 3, 'h80000);
    store_word({7'h20, 5'd1, 5'd1, 3'd1, 5'd1, op_imm});
    illegal_exp++;
    reg_op(0, f_xor, 4, 1, 2);
    reg_op('h20, f_sr, 5, 3, 1);
    upper_op(op_auipc, 6, 'h7);
    reg_op('h20, f_add, 7, 6, 4);
    imm_op(f_sltu, 8, 7, -1);
    imm_op(f_and, 9, 5, 'h7ff);
    run_program();
  endtask

  initial begin
    for (int i = 0; i < 32; i++) begin
      regs_m[i] = 32'd0;
    end
    test_imm_group();
    test_reg_group();
    test_dependences();
    test_upper();
    test_random_waits();
    finish_run(0);
  end

endmodule

`default_nettype wire
